// File: Bender.yml
package:
  name: lpif_slave

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - source/lpif_link_pkg.sv
      - source/ll_sync_pkg.sv
      - source/ll_delay_timer.sv
      - source/ll_auto_sync.sv
      - source/lpif_field_pack.sv
      - source/lpif_phy_concat.sv
      - source/lpif_slave_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/tb_lpif_slave.sv

// File: all.f
source/lpif_link_pkg.sv
source/ll_sync_pkg.sv
source/ll_delay_timer.sv
source/ll_auto_sync.sv
source/lpif_field_pack.sv
source/lpif_phy_concat.sv
source/lpif_slave_top.sv
testbench/tb_lpif_slave.sv

// File: source/ll_auto_sync.sv
`default_nettype none

module ll_auto_sync (
  input  logic                                 clk_wr,
  input  logic                                 rst,
  input  logic                                 tx_online,
  input  logic                                 rx_online,
  input  logic [ll_sync_pkg::delay_width-1:0]  delay_x_value,
  input  logic [ll_sync_pkg::delay_width-1:0]  delay_y_value,
  input  logic [ll_sync_pkg::delay_width-1:0]  delay_z_value,
  input  logic [ll_sync_pkg::marker_width-1:0] tx_mrk_userbit,
  input  logic                                 tx_stb_userbit,
  output logic                                 tx_online_delay,
  output logic                                 rx_online_delay,
  output logic [ll_sync_pkg::marker_width-1:0] tx_auto_mrk_userbit,
  output logic                                 tx_auto_stb_userbit
);

  import ll_sync_pkg::*;

  // Strobe lead-in window is open
  logic stb_active;

  //////////////////////////////////////////////////
  // Transmit side
  // First stage waits delay_z before strobing
  ll_delay_timer u_delay_z (
    .clk_wr (clk_wr),
    .rst    (rst),
    .start  (tx_online),
    .value  (delay_z_value),
    .done   (stb_active)
  );

  // Strobes run delay_y cycles before data is let through
  ll_delay_timer u_delay_y (
    .clk_wr (clk_wr),
    .rst    (rst),
    .start  (stb_active),
    .value  (delay_y_value),
    .done   (tx_online_delay)
  );

  //////////////////////////////////////////////////
  // Receive side
  // Word alignment time before receive is trusted
  ll_delay_timer u_delay_x (
    .clk_wr (clk_wr),
    .rst    (rst),
    .start  (rx_online),
    .value  (delay_x_value),
    .done   (rx_online_delay)
  );

  // Persistent strobe once the lead-in starts
  assign tx_auto_stb_userbit = stb_active | tx_stb_userbit;

  // Persistent marker while transmit is online
  assign tx_auto_mrk_userbit = tx_mrk_userbit |
                               (tx_online ? marker_pattern : {marker_width{1'b0}});

endmodule

`default_nettype wire

// File: source/ll_delay_timer.sv
`default_nettype none

module ll_delay_timer (
  input  logic                            clk_wr,
  input  logic                            rst,
  input  logic                            start,
  input  logic [ll_sync_pkg::delay_width-1:0] value,
  output logic                            done
);

  import ll_sync_pkg::*;

  // Cycles start has been held so far
  logic [delay_width-1:0] count;

  // Count saturates at value
  // Dropping start restarts the qualification
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      count <= '0;
      done  <= 1'b0;
    end else if (!start) begin
      count <= '0;
      done  <= 1'b0;
    end else if (count >= value) begin
      // Held long enough, stays set while start is high
      done  <= 1'b1;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/ll_sync_pkg.sv
`default_nettype none

package ll_sync_pkg;

  // One marker bit per lane word
  localparam int marker_width = 4;

  // Automatic marker on the last lane only
  localparam logic [marker_width-1:0] marker_pattern = 4'b1000;

  // Width of the programmable delay values
  localparam int delay_width = 16;

endpackage

`default_nettype wire

// File: source/lpif_field_pack.sv
`default_nettype none

module lpif_field_pack (
  input  logic                                    clk_wr,
  input  logic                                    rst,
  input  logic                                    rx_online_delay,

  // Upstream channel
  input  logic [lpif_link_pkg::state_width-1:0]     ustrm_state,
  input  logic [lpif_link_pkg::protid_width-1:0]    ustrm_protid,
  input  logic [lpif_link_pkg::data_width-1:0]      ustrm_data,
  input  logic [lpif_link_pkg::dvalid_width-1:0]    ustrm_dvalid,
  input  logic [lpif_link_pkg::crc_width-1:0]       ustrm_crc,
  input  logic [lpif_link_pkg::crc_valid_width-1:0] ustrm_crc_valid,
  input  logic [lpif_link_pkg::valid_width-1:0]     ustrm_valid,

  // Downstream channel
  output logic [lpif_link_pkg::state_width-1:0]     dstrm_state,
  output logic [lpif_link_pkg::protid_width-1:0]    dstrm_protid,
  output logic [lpif_link_pkg::data_width-1:0]      dstrm_data,
  output logic [lpif_link_pkg::dvalid_width-1:0]    dstrm_dvalid,
  output logic [lpif_link_pkg::crc_width-1:0]       dstrm_crc,
  output logic [lpif_link_pkg::crc_valid_width-1:0] dstrm_crc_valid,
  output logic [lpif_link_pkg::valid_width-1:0]     dstrm_valid,

  // Link vectors
  output logic [lpif_link_pkg::link_width-1:0]      txfifo_upstream_data,
  input  logic [lpif_link_pkg::link_width-1:0]      rxfifo_downstream_data
);

  import lpif_link_pkg::*;

  //////////////////////////////////////////////////
  // Transmit packing
  // Plain field placement, no state
  always_comb begin
    txfifo_upstream_data = '0;
    txfifo_upstream_data[state_lsb     +: state_width]     = ustrm_state;
    txfifo_upstream_data[protid_lsb    +: protid_width]    = ustrm_protid;
    txfifo_upstream_data[data_lsb      +: data_width]      = ustrm_data;
    txfifo_upstream_data[dvalid_lsb    +: dvalid_width]    = ustrm_dvalid;
    txfifo_upstream_data[crc_lsb       +: crc_width]       = ustrm_crc;
    txfifo_upstream_data[crc_valid_lsb +: crc_valid_width] = ustrm_crc_valid;
    txfifo_upstream_data[valid_lsb     +: valid_width]     = ustrm_valid;
  end

  //////////////////////////////////////////////////
  // Receive unpacking
  // Fields held at zero until receive alignment is done
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_delay) begin
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= '0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= '0;
      dstrm_valid     <= '0;
    end else begin
      dstrm_state     <= rxfifo_downstream_data[state_lsb     +: state_width];
      dstrm_protid    <= rxfifo_downstream_data[protid_lsb    +: protid_width];
      dstrm_data      <= rxfifo_downstream_data[data_lsb      +: data_width];
      dstrm_dvalid    <= rxfifo_downstream_data[dvalid_lsb    +: dvalid_width];
      dstrm_crc       <= rxfifo_downstream_data[crc_lsb       +: crc_width];
      dstrm_crc_valid <= rxfifo_downstream_data[crc_valid_lsb +: crc_valid_width];
      dstrm_valid     <= rxfifo_downstream_data[valid_lsb     +: valid_width];
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_link_pkg.sv
`default_nettype none

package lpif_link_pkg;

  // Packed link vector and PHY word
  localparam int link_width   = 308;
  localparam int phy_width    = 320;

  // Four lane words at quarter rate
  localparam int lane_count   = 4;
  localparam int lane_width   = 80;
  localparam int lane_payload = 77;

  //////////////////////////////////////////////////
  // Field placement in the link vector
  localparam int state_lsb       = 0;
  localparam int state_width     = 16;
  localparam int protid_lsb      = 16;
  localparam int protid_width    = 8;
  localparam int data_lsb        = 24;
  localparam int data_width      = 256;
  localparam int dvalid_lsb      = 280;
  localparam int dvalid_width    = 4;
  localparam int crc_lsb         = 284;
  localparam int crc_width       = 16;
  localparam int crc_valid_lsb   = 300;
  localparam int crc_valid_width = 4;
  localparam int valid_lsb       = 304;
  localparam int valid_width     = 4;

  //////////////////////////////////////////////////
  // Reserved bits inside each lane word
  localparam int strobe_bit      = 1;
  localparam int marker_bit_gen2 = 79;
  localparam int spare_bit_gen2  = 78;
  localparam int marker_bit_gen1 = 39;
  localparam int spare_bit_gen1  = 79;

endpackage

`default_nettype wire

// File: source/lpif_phy_concat.sv
`default_nettype none

module lpif_phy_concat (
  input  logic                                 clk_wr,
  input  logic                                 rst,
  input  logic                                 m_gen2_mode,
  input  logic                                 tx_online,
  input  logic                                 tx_stb_userbit,
  input  logic [ll_sync_pkg::marker_width-1:0] tx_mrk_userbit,
  input  logic [lpif_link_pkg::link_width-1:0] tx_upstream_data,
  output logic [lpif_link_pkg::link_width-1:0] rx_downstream_data,
  output logic [lpif_link_pkg::phy_width-1:0]  tx_phy0,
  input  logic [lpif_link_pkg::phy_width-1:0]  rx_phy0
);

  import lpif_link_pkg::*;

  // Payload after online gating
  logic [link_width-1:0] tx_payload;
  // Next PHY word before the output register
  logic [phy_width-1:0]  tx_phy_next;

  // Strobe, marker or spare slot for the active mode
  function automatic logic is_reserved(input int pos, input logic gen2);
    logic hit;
    hit = (pos == strobe_bit);
    if (gen2) begin
      hit = hit || (pos == marker_bit_gen2) || (pos == spare_bit_gen2);
    end else begin
      hit = hit || (pos == marker_bit_gen1) || (pos == spare_bit_gen1);
    end
    return hit;
  endfunction

  // Payload bits fill free slots in ascending order
  function automatic logic [lane_width-1:0] lane_insert(
    input logic [lane_payload-1:0] payload,
    input logic                    gen2
  );
    logic [lane_width-1:0] word;
    int j;
    word = '0;
    j = 0;
    for (int p = 0; p < lane_width; p++) begin
      if (!is_reserved(p, gen2)) begin
        word[p] = payload[j];
        j++;
      end
    end
    return word;
  endfunction

  // Inverse of lane_insert
  function automatic logic [lane_payload-1:0] lane_extract(
    input logic [lane_width-1:0] word,
    input logic                  gen2
  );
    logic [lane_payload-1:0] payload;
    int j;
    payload = '0;
    j = 0;
    for (int p = 0; p < lane_width; p++) begin
      if (!is_reserved(p, gen2)) begin
        payload[j] = word[p];
        j++;
      end
    end
    return payload;
  endfunction

  //////////////////////////////////////////////////
  // Transmit lane words
  // Markers and strobe still go out while payload is held off
  assign tx_payload = tx_online ? tx_upstream_data : '0;

  always_comb begin
    tx_phy_next = '0;
    for (int w = 0; w < lane_count; w++) begin
      tx_phy_next[w*lane_width +: lane_width] =
        lane_insert(tx_payload[w*lane_payload +: lane_payload], m_gen2_mode);
      // One marker userbit per lane
      if (m_gen2_mode) begin
        tx_phy_next[w*lane_width + marker_bit_gen2] = tx_mrk_userbit[w];
      end else begin
        tx_phy_next[w*lane_width + marker_bit_gen1] = tx_mrk_userbit[w];
      end
    end
    // Strobe on lane 0 only
    tx_phy_next[strobe_bit] = tx_stb_userbit;
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_phy_next;
    end
  end

  //////////////////////////////////////////////////
  // Receive payload extraction
  always_ff @(posedge clk_wr) begin
    for (int w = 0; w < lane_count; w++) begin
      rx_downstream_data[w*lane_payload +: lane_payload] <=
        lane_extract(rx_phy0[w*lane_width +: lane_width], m_gen2_mode);
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_slave_top.sv
`default_nettype none

module lpif_slave_top (
  input  logic                                     clk_wr,
  input  logic                                     rst,

  // Link control
  input  logic                                     tx_online,
  input  logic                                     rx_online,

  // PHY side
  output logic [lpif_link_pkg::phy_width-1:0]        tx_phy0,
  input  logic [lpif_link_pkg::phy_width-1:0]        rx_phy0,

  // Downstream channel
  output logic [lpif_link_pkg::state_width-1:0]      dstrm_state,
  output logic [lpif_link_pkg::protid_width-1:0]     dstrm_protid,
  output logic [lpif_link_pkg::data_width-1:0]       dstrm_data,
  output logic [lpif_link_pkg::dvalid_width-1:0]     dstrm_dvalid,
  output logic [lpif_link_pkg::crc_width-1:0]        dstrm_crc,
  output logic [lpif_link_pkg::crc_valid_width-1:0]  dstrm_crc_valid,
  output logic [lpif_link_pkg::valid_width-1:0]      dstrm_valid,

  // Upstream channel
  input  logic [lpif_link_pkg::state_width-1:0]      ustrm_state,
  input  logic [lpif_link_pkg::protid_width-1:0]     ustrm_protid,
  input  logic [lpif_link_pkg::data_width-1:0]       ustrm_data,
  input  logic [lpif_link_pkg::dvalid_width-1:0]     ustrm_dvalid,
  input  logic [lpif_link_pkg::crc_width-1:0]        ustrm_crc,
  input  logic [lpif_link_pkg::crc_valid_width-1:0]  ustrm_crc_valid,
  input  logic [lpif_link_pkg::valid_width-1:0]      ustrm_valid,

  // Static configuration
  input  logic                                     m_gen2_mode,
  input  logic [ll_sync_pkg::marker_width-1:0]       tx_mrk_userbit,
  input  logic                                     tx_stb_userbit,
  input  logic [ll_sync_pkg::delay_width-1:0]        delay_x_value,
  input  logic [ll_sync_pkg::delay_width-1:0]        delay_y_value,
  input  logic [ll_sync_pkg::delay_width-1:0]        delay_z_value
);

  import lpif_link_pkg::*;
  import ll_sync_pkg::*;

  // Auto sync outputs
  logic                    tx_online_delay;
  logic                    rx_online_delay;
  logic [marker_width-1:0] tx_auto_mrk_userbit;
  logic                    tx_auto_stb_userbit;

  // Link vectors, FIFO and credit stage bypassed
  logic [link_width-1:0]   txfifo_upstream_data;
  logic [link_width-1:0]   rxfifo_downstream_data;

  //////////////////////////////////////////////////
  // Strobe, marker and online sequencing
  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst                 (rst),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  //////////////////////////////////////////////////
  // User channel fields
  lpif_field_pack u_field_pack (
    .clk_wr                 (clk_wr),
    .rst                    (rst),
    .rx_online_delay        (rx_online_delay),
    .ustrm_state            (ustrm_state),
    .ustrm_protid           (ustrm_protid),
    .ustrm_data             (ustrm_data),
    .ustrm_dvalid           (ustrm_dvalid),
    .ustrm_crc              (ustrm_crc),
    .ustrm_crc_valid        (ustrm_crc_valid),
    .ustrm_valid            (ustrm_valid),
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .dstrm_dvalid           (dstrm_dvalid),
    .dstrm_crc              (dstrm_crc),
    .dstrm_crc_valid        (dstrm_crc_valid),
    .dstrm_valid            (dstrm_valid),
    .txfifo_upstream_data   (txfifo_upstream_data),
    .rxfifo_downstream_data (rxfifo_downstream_data)
  );

  //////////////////////////////////////////////////
  // Lane words on the PHY
  // Payload gated by the delayed transmit online
  lpif_phy_concat u_phy_concat (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .m_gen2_mode        (m_gen2_mode),
    .tx_online          (tx_online_delay),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_upstream_data   (txfifo_upstream_data),
    .rx_downstream_data (rxfifo_downstream_data),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0)
  );

endmodule

`default_nettype wire

// File: testbench/tb_lpif_slave.sv
`default_nettype none

module tb_lpif_slave;

  import lpif_link_pkg::*;
  import ll_sync_pkg::*;

  //////////////////////////////////////////////////
  // Run length
  // Reset and tests 1 to 5 with tests 3 and 5 run in both modes
  localparam int test_cycles    = 4 + 8 + 16 + 2 * 21 + 2 * 22;
  localparam int timeout_cycles = test_cycles + 200;

  // Clock and reset
  logic clk_wr = 1'b0;
  logic rst;

  // DUT inputs
  logic                    tx_online;
  logic                    rx_online;
  logic [phy_width-1:0]    rx_phy0;
  logic [15:0]             ustrm_state;
  logic [7:0]              ustrm_protid;
  logic [255:0]            ustrm_data;
  logic [3:0]              ustrm_dvalid;
  logic [15:0]             ustrm_crc;
  logic [3:0]              ustrm_crc_valid;
  logic [3:0]              ustrm_valid;
  logic                    m_gen2_mode;
  logic [marker_width-1:0] tx_mrk_userbit;
  logic                    tx_stb_userbit;
  logic [delay_width-1:0]  delay_x_value;
  logic [delay_width-1:0]  delay_y_value;
  logic [delay_width-1:0]  delay_z_value;

  // DUT outputs
  logic [phy_width-1:0]    tx_phy0;
  logic [15:0]             dstrm_state;
  logic [7:0]              dstrm_protid;
  logic [255:0]            dstrm_data;
  logic [3:0]              dstrm_dvalid;
  logic [15:0]             dstrm_crc;
  logic [3:0]              dstrm_crc_valid;
  logic [3:0]              dstrm_valid;

  // PHY loopback switch or direct drive
  logic                    loopback;
  logic [phy_width-1:0]    rx_phy_drv;

  logic [31:0]             lfsr;
  int                      error_count = 0;
  int                      cycle_count = 0;

  assign rx_phy0 = loopback ? tx_phy0 : rx_phy_drv;

  always #4 clk_wr = ~clk_wr;

  lpif_slave_top DUT (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy0         (tx_phy0),
    .rx_phy0         (rx_phy0),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .m_gen2_mode     (m_gen2_mode),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value)
  );

  // Hang guard
  always @(posedge clk_wr) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Test failed");
      $fatal(1, "Run did not finish within %0d cycles", timeout_cycles);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and reference helpers
  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [255:0] random_bits(input int nbits);
    logic [255:0] val;
    logic         fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val[i] = fb;
    end
    return val;
  endfunction

  task automatic randomize_fields();
    logic [255:0] tmp;
    tmp = random_bits(16);
    ustrm_state = tmp[15:0];
    tmp = random_bits(8);
    ustrm_protid = tmp[7:0];
    ustrm_data = random_bits(256);
    tmp = random_bits(12);
    ustrm_dvalid    = tmp[3:0];
    ustrm_crc_valid = tmp[7:4];
    ustrm_valid     = tmp[11:8];
    tmp = random_bits(16);
    ustrm_crc = tmp[15:0];
  endtask

  // Link vector in field order with state at bit 0
  function automatic logic [link_width-1:0] pack_link();
    return {ustrm_valid, ustrm_crc_valid, ustrm_crc, ustrm_dvalid,
            ustrm_data, ustrm_protid, ustrm_state};
  endfunction

  // Expected PHY word from the lane layout rule
  function automatic logic [phy_width-1:0] build_phy(
    input logic [link_width-1:0]   link,
    input logic [marker_width-1:0] mrk,
    input logic                    stb,
    input logic                    gen2
  );
    logic [phy_width-1:0] phy;
    int marker_pos;
    int spare_pos;
    int pos;
    phy = '0;
    marker_pos = gen2 ? 79 : 39;
    spare_pos  = gen2 ? 78 : 79;
    for (int w = 0; w < lane_count; w++) begin
      pos = 0;
      for (int k = 0; k < lane_payload; k++) begin
        // Step over strobe marker and spare slots
        while (pos == 1 || pos == marker_pos || pos == spare_pos) begin
          pos++;
        end
        phy[w*lane_width + pos] = link[w*lane_payload + k];
        pos++;
      end
      phy[w*lane_width + marker_pos] = mrk[w];
    end
    phy[1] = stb;
    return phy;
  endfunction

  task automatic check_value(
    input string                name,
    input logic [phy_width-1:0] got,
    input logic [phy_width-1:0] exp
  );
    if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Stopped at first wrong value");
    end
  endtask

  task automatic check_dstrm(input logic [link_width-1:0] exp);
    check_value("dstrm_state", dstrm_state, exp[state_lsb +: state_width]);
    check_value("dstrm_protid", dstrm_protid, exp[protid_lsb +: protid_width]);
    check_value("dstrm_data", dstrm_data, exp[data_lsb +: data_width]);
    check_value("dstrm_dvalid", dstrm_dvalid, exp[dvalid_lsb +: dvalid_width]);
    check_value("dstrm_crc", dstrm_crc, exp[crc_lsb +: crc_width]);
    check_value("dstrm_crc_valid", dstrm_crc_valid,
                exp[crc_valid_lsb +: crc_valid_width]);
    check_value("dstrm_valid", dstrm_valid, exp[valid_lsb +: valid_width]);
  endtask

  //////////////////////////////////////////////////
  // Test 1 covers the idle link after reset
  task automatic reset_state();
    logic [255:0] noise_hi;
    logic [255:0] noise_lo;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_wr);
      check_value("tx_phy0", tx_phy0, '0);
      check_dstrm('0);
      // Noise on the PHY input must not leak through
      noise_hi = random_bits(64);
      noise_lo = random_bits(256);
      rx_phy_drv = {noise_hi[63:0], noise_lo};
      randomize_fields();
    end
  endtask

  // Test 2 covers the strobe lead-in and payload release
  task automatic online_lead_in();
    logic [link_width-1:0] prev_link;
    logic [link_width-1:0] payload;
    logic [phy_width-1:0]  exp;
    int z;
    int y;
    z = 3;
    y = 5;
    @(negedge clk_wr);
    delay_z_value = 16'd3;
    delay_y_value = 16'd5;
    tx_online = 1'b1;
    randomize_fields();
    prev_link = pack_link();
    for (int i = 1; i <= z + y + 3 + 4; i++) begin
      @(negedge clk_wr);
      // Strobe after z+1 samples plus the output register
      payload = (i >= z + y + 3) ? prev_link : '0;
      exp = build_phy(payload, 4'b1000, i >= z + 2, 1'b1);
      check_value("tx_phy0 strobe lane0", tx_phy0[strobe_bit], i >= z + 2);
      check_value("tx_phy0 marker lane3", tx_phy0[3*lane_width + marker_bit_gen2], 1'b1);
      check_value("tx_phy0", tx_phy0, exp);
      randomize_fields();
      prev_link = pack_link();
    end
  endtask

  // Tests 3 and 4 compare random words with the reference layout
  task automatic lane_layout(input logic gen2);
    logic [phy_width-1:0]    exp;
    logic [marker_width-1:0] exp_mrk;
    logic [255:0]            tmp;
    @(negedge clk_wr);
    m_gen2_mode = gen2;
    for (int i = 0; i <= 20; i++) begin
      if (i > 0) begin
        @(negedge clk_wr);
        if (!gen2) begin
          for (int w = 0; w < lane_count; w++) begin
            check_value("tx_phy0 gen1 marker", tx_phy0[w*lane_width + 39], exp_mrk[w]);
            check_value("tx_phy0 gen1 spare", tx_phy0[w*lane_width + 79], 1'b0);
          end
        end
        check_value("tx_phy0", tx_phy0, exp);
      end
      randomize_fields();
      tmp = random_bits(5);
      tx_mrk_userbit = tmp[3:0];
      tx_stb_userbit = tmp[4];
      // Auto pattern and lead-in strobe merged with user bits
      exp_mrk = tx_mrk_userbit | 4'b1000;
      exp = build_phy(pack_link(), exp_mrk, 1'b1, gen2);
    end
  endtask

  // Test 5 covers receive qualification over PHY loopback
  task automatic rx_qualify(input logic gen2);
    logic [link_width-1:0] sent [0:31];
    logic [link_width-1:0] exp;
    int x;
    x = 4;
    @(negedge clk_wr);
    rx_online = 1'b0;
    m_gen2_mode = gen2;
    loopback = 1'b1;
    delay_x_value = 16'd4;
    // Timer and output register drain
    repeat (3) @(negedge clk_wr);
    check_dstrm('0);
    rx_online = 1'b1;
    randomize_fields();
    sent[0] = pack_link();
    for (int i = 1; i <= x + 2 + 12; i++) begin
      @(negedge clk_wr);
      // Three cycles from ustrm to dstrm
      exp = (i >= x + 2) ? sent[i-3] : '0;
      check_dstrm(exp);
      randomize_fields();
      sent[i] = pack_link();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  initial begin
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = '0;
    ustrm_crc       = '0;
    ustrm_crc_valid = '0;
    ustrm_valid     = '0;
    m_gen2_mode     = 1'b1;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    delay_z_value   = '0;
    loopback        = 1'b0;
    rx_phy_drv      = '0;
    lfsr            = 32'hccc8;
    repeat (4) @(negedge clk_wr);
    rst = 1'b0;
    reset_state();
    online_lead_in();
    lane_layout(1'b1);
    lane_layout(1'b0);
    rx_qualify(1'b1);
    rx_qualify(1'b0);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
